/* core_pkg.sv */
////////////////////
// shared definitions for the emulator glue logic
// bridge widths, setting register addresses and field types
// every file refers to these by core_pkg:: scoped names
////////////////////

package core_pkg;

    // host bridge bus
    localparam int BRIDGE_ADDR_W = 32;
    localparam int BRIDGE_DATA_W = 32;

    ////////////////////
    // setting register map
    ////////////////////

    // writing here starts the core reset hold
    localparam logic [BRIDGE_ADDR_W-1:0] ADDR_RESET    = 32'h050;

    localparam logic [BRIDGE_ADDR_W-1:0] ADDR_MAPPER   = 32'h200;
    localparam logic [BRIDGE_ADDR_W-1:0] ADDR_RUMBLE   = 32'h204;
    localparam logic [BRIDGE_ADDR_W-1:0] ADDR_SYS_TYPE = 32'h208;
    localparam logic [BRIDGE_ADDR_W-1:0] ADDR_FF_SND   = 32'h20C;
    localparam logic [BRIDGE_ADDR_W-1:0] ADDR_TINT     = 32'h210;
    localparam logic [BRIDGE_ADDR_W-1:0] ADDR_SGB      = 32'h214;
    localparam logic [BRIDGE_ADDR_W-1:0] ADDR_SGB_GBC  = 32'h218;
    localparam logic [BRIDGE_ADDR_W-1:0] ADDR_REWIND   = 32'h21C;

    ////////////////////
    // setting field types
    ////////////////////

    typedef logic [2:0] mapper_t;

    typedef enum logic [1:0] {
        SYS_AUTO     = 2'd0,
        SYS_DMG      = 2'd1,
        SYS_GBC      = 2'd2,
        SYS_MEGADUCK = 2'd3
    } sys_type_t;

    typedef logic [1:0] tint_t;

    // bit 1 enables the border
    typedef logic [1:0] sgb_mode_t;

    // audio and video payloads
    typedef logic signed [15:0] sample_t;
    typedef logic [23:0] rgb_t;

    // trig_l1 in the controller key bitmap
    localparam int FF_KEY_BIT = 8;

endpackage

/* core_settings_if.sv */
////////////////////
// decoded settings plus the core reset hold
// driven by the register block, read by fast-forward logic and top
////////////////////

interface core_settings_if;

    core_pkg::mapper_t   mapper_sel;
    logic                rumble_en;
    core_pkg::sys_type_t sys_type;
    logic                ff_snd_en;
    core_pkg::tint_t     tint;
    core_pkg::sgb_mode_t sgb_mode;
    logic                sgb_gbc_en;
    logic                rw_en;
    // high while the reset hold runs
    logic                core_reset;

    modport regs_side (
        output mapper_sel, rumble_en, sys_type, ff_snd_en, tint,
        output sgb_mode, sgb_gbc_en, rw_en, core_reset
    );

    modport consumer (
        input mapper_sel, rumble_en, sys_type, ff_snd_en, tint,
        input sgb_mode, sgb_gbc_en, rw_en, core_reset
    );

endinterface

/* bridge_config_regs.sv */
////////////////////
// setting registers written over the host bridge
// a write to the reset address holds core_reset for a fixed count
////////////////////

module bridge_config_regs #(
    parameter int RESET_HOLD_CYCLES = 32'h100000
) (
    input  logic                               clk_sys,
    input  logic                               reset,
    input  logic [core_pkg::BRIDGE_ADDR_W-1:0] bridge_addr,
    input  logic                               bridge_wr,
    input  logic [core_pkg::BRIDGE_DATA_W-1:0] bridge_wr_data,
    core_settings_if.regs_side                 settings
);

    localparam int HOLD_W = $clog2(RESET_HOLD_CYCLES + 1);

    logic [HOLD_W-1:0] hold_cnt;

    ////////////////////
    // field decode
    ////////////////////

    // full address compare, low data bits go into the field
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            settings.mapper_sel <= '0;
            settings.rumble_en  <= 1'b0;
            settings.sys_type   <= core_pkg::SYS_AUTO;
            settings.ff_snd_en  <= 1'b0;
            settings.tint       <= '0;
            settings.sgb_mode   <= '0;
            settings.sgb_gbc_en <= 1'b0;
            settings.rw_en      <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                core_pkg::ADDR_MAPPER: begin
                    settings.mapper_sel <= bridge_wr_data[2:0];
                end
                core_pkg::ADDR_RUMBLE: begin
                    settings.rumble_en <= bridge_wr_data[0];
                end
                core_pkg::ADDR_SYS_TYPE: begin
                    settings.sys_type <= core_pkg::sys_type_t'(bridge_wr_data[1:0]);
                end
                core_pkg::ADDR_FF_SND: begin
                    settings.ff_snd_en <= bridge_wr_data[0];
                end
                core_pkg::ADDR_TINT: begin
                    settings.tint <= bridge_wr_data[1:0];
                end
                core_pkg::ADDR_SGB: begin
                    settings.sgb_mode <= bridge_wr_data[1:0];
                end
                core_pkg::ADDR_SGB_GBC: begin
                    settings.sgb_gbc_en <= bridge_wr_data[0];
                end
                core_pkg::ADDR_REWIND: begin
                    settings.rw_en <= bridge_wr_data[0];
                end
                default: begin
                    // other addresses belong to other devices
                end
            endcase
        end
    end

    ////////////////////
    // reset hold
    ////////////////////

    // a rewrite during the hold reloads the full count
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hold_cnt <= '0;
        end else if (bridge_wr && bridge_addr == core_pkg::ADDR_RESET) begin
            hold_cnt <= HOLD_W'(RESET_HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign settings.core_reset = (hold_cnt != '0);

    // system reset always ends any pending hold
    a_no_hold_after_reset : assert property (
        @(posedge clk_sys) reset |=> !settings.core_reset
    );

endmodule

/* fast_forward_ctrl.sv */
////////////////////
// fast-forward button handling and audio muting
// a short tap latches fast-forward, a long hold only acts while held
// audio is muted during fast-forward unless sound is enabled
////////////////////

module fast_forward_ctrl #(
    parameter int FF_HOLD_CYCLES = 3200000
) (
    input  logic              clk_sys,
    input  logic              reset,
    input  logic              ff_key,
    input  logic              loader_busy,
    core_settings_if.consumer settings,
    input  core_pkg::sample_t audio_l_in,
    input  core_pkg::sample_t audio_r_in,
    output logic              fast_forward,
    output core_pkg::sample_t audio_l,
    output core_pkg::sample_t audio_r
);

    localparam int CNT_W = $clog2(FF_HOLD_CYCLES + 1);

    logic             button;
    logic             button_q;
    logic             ff_latch;
    logic             ff_was_held;
    logic [CNT_W-1:0] ff_count;
    logic             mute;

    // key is ignored while a download is running
    assign button = ff_key & ~loader_busy;

    ////////////////////
    // tap / hold latch
    ////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            button_q     <= 1'b0;
            ff_latch     <= 1'b0;
            ff_was_held  <= 1'b0;
            ff_count     <= '0;
            fast_forward <= 1'b0;
        end else begin
            button_q <= button;

            // count held cycles, saturating
            if (button && ff_count != CNT_W'(FF_HOLD_CYCLES)) begin
                ff_count <= ff_count + 1'b1;
            end

            // press clears the latch and restarts the count
            if (button && !button_q) begin
                ff_latch <= 1'b0;
                ff_count <= '0;
            end

            // release: short tap latches, unless the last release already did
            if (!button && button_q) begin
                ff_was_held <= 1'b0;
                if (ff_count < CNT_W'(FF_HOLD_CYCLES) && !ff_was_held) begin
                    ff_was_held <= 1'b1;
                    ff_latch    <= 1'b1;
                end
            end

            fast_forward <= button_q | ff_latch;
        end
    end

    ////////////////////
    // audio path
    ////////////////////

    assign mute = fast_forward & ~settings.ff_snd_en;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            audio_l <= '0;
            audio_r <= '0;
        end else begin
            audio_l <= mute ? '0 : audio_l_in;
            audio_r <= mute ? '0 : audio_r_in;
        end
    end

    a_muted_audio_zero : assert property (
        @(posedge clk_sys) disable iff (reset)
        mute |=> (audio_l == '0 && audio_r == '0)
    );

endmodule

/* video_sync_shaper.sv */
////////////////////
// shapes the lcd timing for the scaler
// pixels gated by blanking, vs as a one-cycle pulse,
// hs delayed by HS_DELAY so it does not overlap vs
////////////////////

module video_sync_shaper #(
    parameter int HS_DELAY = 7
) (
    input  logic           clk_sys,
    input  logic           reset,
    input  logic           lcd_hs,
    input  logic           lcd_vs,
    input  logic           lcd_hblank,
    input  logic           lcd_vblank,
    input  core_pkg::rgb_t lcd_rgb,
    output logic           video_de,
    output logic           video_hs,
    output logic           video_vs,
    output core_pkg::rgb_t video_rgb
);

    localparam int DLY_W = $clog2(HS_DELAY + 1);

    logic             de;
    logic             hs_prev;
    logic             vs_prev;
    logic [DLY_W-1:0] hs_cnt;

    assign de = ~(lcd_hblank | lcd_vblank);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
            hs_cnt    <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
            video_rgb <= '0;
        end else begin
            hs_prev <= lcd_hs;
            vs_prev <= lcd_vs;

            video_de  <= de;
            video_rgb <= de ? lcd_rgb : '0;

            // vs pulse right after the rising edge
            video_vs <= lcd_vs & ~vs_prev;

            // last count step fires the hs pulse
            video_hs <= (hs_cnt == DLY_W'(1));

            // new hs edge restarts the delay
            if (lcd_hs && !hs_prev) begin
                hs_cnt <= DLY_W'(HS_DELAY);
            end else if (hs_cnt != '0) begin
                hs_cnt <= hs_cnt - 1'b1;
            end
        end
    end

    a_hs_single_cycle : assert property (
        @(posedge clk_sys) disable iff (reset) video_hs |=> !video_hs
    );

    a_rgb_blanked : assert property (
        @(posedge clk_sys) disable iff (reset) !video_de |-> (video_rgb == '0)
    );

endmodule

/* core_glue_top.sv */
////////////////////
// top level of the emulator glue logic, single clock clk_sys
// ties the settings registers, fast-forward and video shaping together
////////////////////

module core_glue_top #(
    parameter int RESET_HOLD_CYCLES = 32'h100000,
    parameter int FF_HOLD_CYCLES    = 3200000,
    parameter int HS_DELAY          = 7
) (
    input  logic                               clk_sys,
    input  logic                               reset,
    // host bridge
    input  logic [core_pkg::BRIDGE_ADDR_W-1:0] bridge_addr,
    input  logic                               bridge_wr,
    input  logic [core_pkg::BRIDGE_DATA_W-1:0] bridge_wr_data,
    input  logic [31:0]                        cont1_key,
    input  logic                               loader_busy,
    input  core_pkg::sample_t                  audio_l_in,
    input  core_pkg::sample_t                  audio_r_in,
    // lcd timing from the core
    input  logic                               lcd_hs,
    input  logic                               lcd_vs,
    input  logic                               lcd_hblank,
    input  logic                               lcd_vblank,
    input  core_pkg::rgb_t                     lcd_rgb,
    // settings
    output logic                               core_reset,
    output core_pkg::mapper_t                  mapper_sel,
    output logic                               rumble_en,
    output core_pkg::sys_type_t                sys_type,
    output core_pkg::tint_t                    tint,
    output core_pkg::sgb_mode_t                sgb_mode,
    output logic                               sgb_gbc_en,
    output logic                               rw_en,
    // fast-forward and audio
    output logic                               fast_forward,
    output core_pkg::sample_t                  audio_l,
    output core_pkg::sample_t                  audio_r,
    // video to the scaler
    output logic                               video_de,
    output logic                               video_hs,
    output logic                               video_vs,
    output core_pkg::rgb_t                     video_rgb
);

    logic ff_key;

    core_settings_if settings_bus ();

    assign ff_key = cont1_key[core_pkg::FF_KEY_BIT];

    bridge_config_regs #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
    ) bridge_config_regs_inst (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .settings       (settings_bus.regs_side)
    );

    fast_forward_ctrl #(
        .FF_HOLD_CYCLES (FF_HOLD_CYCLES)
    ) fast_forward_ctrl_inst (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .ff_key       (ff_key),
        .loader_busy  (loader_busy),
        .settings     (settings_bus.consumer),
        .audio_l_in   (audio_l_in),
        .audio_r_in   (audio_r_in),
        .fast_forward (fast_forward),
        .audio_l      (audio_l),
        .audio_r      (audio_r)
    );

    video_sync_shaper #(
        .HS_DELAY (HS_DELAY)
    ) video_sync_shaper_inst (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .lcd_hs     (lcd_hs),
        .lcd_vs     (lcd_vs),
        .lcd_hblank (lcd_hblank),
        .lcd_vblank (lcd_vblank),
        .lcd_rgb    (lcd_rgb),
        .video_de   (video_de),
        .video_hs   (video_hs),
        .video_vs   (video_vs),
        .video_rgb  (video_rgb)
    );

    // remaining setting fields go straight out
    assign core_reset = settings_bus.core_reset;
    assign mapper_sel = settings_bus.mapper_sel;
    assign rumble_en  = settings_bus.rumble_en;
    assign sys_type   = settings_bus.sys_type;
    assign tint       = settings_bus.tint;
    assign sgb_mode   = settings_bus.sgb_mode;
    assign sgb_gbc_en = settings_bus.sgb_gbc_en;
    assign rw_en      = settings_bus.rw_en;

endmodule

/* tb_core_glue.sv */
////////////////////
// testbench for core_glue_top
// a cycle model built from reference functions runs beside the DUT
// and a negedge process compares every output, directed checks add counts
////////////////////

module tb_core_glue;

    localparam int RESET_HOLD = 20;
    localparam int FF_HOLD    = 16;
    localparam int HS_DLY     = 7;
    localparam int TIMEOUT    = 200;

    localparam logic [31:0] KEY_MASK = 32'h1 << core_pkg::FF_KEY_BIT;

    // DUT inputs, all start at a known value
    logic              clk_sys        = 1'b0;
    logic              reset          = 1'b1;
    logic [31:0]       bridge_addr    = '0;
    logic              bridge_wr      = 1'b0;
    logic [31:0]       bridge_wr_data = '0;
    logic [31:0]       cont1_key      = '0;
    logic              loader_busy    = 1'b0;
    core_pkg::sample_t audio_l_in     = '0;
    core_pkg::sample_t audio_r_in     = '0;
    logic              lcd_hs         = 1'b0;
    logic              lcd_vs         = 1'b0;
    logic              lcd_hblank     = 1'b0;
    logic              lcd_vblank     = 1'b0;
    core_pkg::rgb_t    lcd_rgb        = '0;

    logic                core_reset;
    core_pkg::mapper_t   mapper_sel;
    logic                rumble_en;
    core_pkg::sys_type_t sys_type;
    core_pkg::tint_t     tint;
    core_pkg::sgb_mode_t sgb_mode;
    logic                sgb_gbc_en;
    logic                rw_en;
    logic                fast_forward;
    core_pkg::sample_t   audio_l;
    core_pkg::sample_t   audio_r;
    logic                video_de;
    logic                video_hs;
    logic                video_vs;
    core_pkg::rgb_t      video_rgb;

    int          seed            = 36223;
    logic [31:0] rand_word       = '0;
    int          model_errors    = 0;
    int          directed_errors = 0;
    int          timeouts        = 0;
    string       test_name       = "reset";

    // field slots: mapper, rumble, sys_type, ff_snd, tint, sgb, sgb_gbc, rewind
    logic [31:0] field_addr [8] = '{core_pkg::ADDR_MAPPER, core_pkg::ADDR_RUMBLE,
        core_pkg::ADDR_SYS_TYPE, core_pkg::ADDR_FF_SND, core_pkg::ADDR_TINT,
        core_pkg::ADDR_SGB, core_pkg::ADDR_SGB_GBC, core_pkg::ADDR_REWIND};

    // model state
    logic [31:0]       m_fld [8];
    int                m_hold;
    int                m_cnt;
    int                m_hs_cnt;
    logic              m_btn_q;
    logic              m_latch;
    logic              m_was_held;
    logic              m_ff;
    core_pkg::sample_t m_aud_l;
    core_pkg::sample_t m_aud_r;
    logic              m_de;
    logic              m_hs;
    logic              m_vs;
    logic              m_hs_prev;
    logic              m_vs_prev;
    core_pkg::rgb_t    m_rgb;

    core_glue_top #(
        .RESET_HOLD_CYCLES (RESET_HOLD),
        .FF_HOLD_CYCLES    (FF_HOLD),
        .HS_DELAY          (HS_DLY)
    ) core_glue_top_inst (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .cont1_key      (cont1_key),
        .loader_busy    (loader_busy),
        .audio_l_in     (audio_l_in),
        .audio_r_in     (audio_r_in),
        .lcd_hs         (lcd_hs),
        .lcd_vs         (lcd_vs),
        .lcd_hblank     (lcd_hblank),
        .lcd_vblank     (lcd_vblank),
        .lcd_rgb        (lcd_rgb),
        .core_reset     (core_reset),
        .mapper_sel     (mapper_sel),
        .rumble_en      (rumble_en),
        .sys_type       (sys_type),
        .tint           (tint),
        .sgb_mode       (sgb_mode),
        .sgb_gbc_en     (sgb_gbc_en),
        .rw_en          (rw_en),
        .fast_forward   (fast_forward),
        .audio_l        (audio_l),
        .audio_r        (audio_r),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs),
        .video_rgb      (video_rgb)
    );

    initial begin
        forever #2 clk_sys = ~clk_sys;
    end

    ////////////////////
    // reference functions
    ////////////////////

    // setting address to field slot, -1 for any other address
    function automatic int field_index(input logic [31:0] addr);
        for (int i = 0; i < 8; i++) begin
            if (field_addr[i] == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic [31:0] field_mask(input int idx);
        case (idx)
            0:       return 32'h7;
            2, 4, 5: return 32'h3;
            default: return 32'h1;
        endcase
    endfunction

    // press clears, a short release sets unless the last release did
    function automatic logic latch_next(input logic latch, input logic press,
                                        input logic rel, input logic short_tap,
                                        input logic was_held);
        if (press) begin
            return 1'b0;
        end
        if (rel && short_tap && !was_held) begin
            return 1'b1;
        end
        return latch;
    endfunction

    function automatic core_pkg::sample_t mute_result(input core_pkg::sample_t s,
                                                      input logic ff, input logic snd_en);
        return (ff && !snd_en) ? '0 : s;
    endfunction

    ////////////////////
    // cycle model and comparison
    ////////////////////

    always @(posedge clk_sys) begin : cycle_model
        logic btn;
        logic press;
        logic rel;
        logic hs_rise;
        int   idx;
        btn     = ((cont1_key & KEY_MASK) != 0) && !loader_busy;
        press   = btn && !m_btn_q;
        rel     = !btn && m_btn_q;
        hs_rise = lcd_hs && !m_hs_prev;
        idx     = field_index(bridge_addr);
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                m_fld[i] = '0;
            end
            m_hold     = 0;
            m_cnt      = 0;
            m_hs_cnt   = 0;
            m_btn_q    = 1'b0;
            m_latch    = 1'b0;
            m_was_held = 1'b0;
            m_ff       = 1'b0;
            m_aud_l    = '0;
            m_aud_r    = '0;
            m_de       = 1'b0;
            m_hs       = 1'b0;
            m_vs       = 1'b0;
            m_hs_prev  = 1'b0;
            m_vs_prev  = 1'b0;
            m_rgb      = '0;
        end else begin
            // muting looks at this cycle's fast_forward and sound enable
            m_aud_l = mute_result(audio_l_in, m_ff, m_fld[3][0]);
            m_aud_r = mute_result(audio_r_in, m_ff, m_fld[3][0]);
            m_ff    = m_btn_q | m_latch;
            m_latch = latch_next(m_latch, press, rel, m_cnt < FF_HOLD, m_was_held);
            if (rel) begin
                m_was_held = (m_cnt < FF_HOLD) && !m_was_held;
            end
            if (press) begin
                m_cnt = 0;
            end else if (btn && m_cnt != FF_HOLD) begin
                m_cnt++;
            end
            m_btn_q = btn;

            if (bridge_wr && bridge_addr == core_pkg::ADDR_RESET) begin
                m_hold = RESET_HOLD;
            end else if (m_hold > 0) begin
                m_hold--;
            end
            if (bridge_wr && idx >= 0) begin
                m_fld[idx] = bridge_wr_data & field_mask(idx);
            end

            m_de = !(lcd_hblank || lcd_vblank);
            m_rgb = m_de ? lcd_rgb : '0;
            m_vs = lcd_vs && !m_vs_prev;
            // hs pulse once the delay from the last rising edge runs out
            m_hs = (m_hs_cnt == 1);
            if (hs_rise) begin
                m_hs_cnt = HS_DLY;
            end else if (m_hs_cnt > 0) begin
                m_hs_cnt--;
            end
            m_hs_prev = lcd_hs;
            m_vs_prev = lcd_vs;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual, inout int count);
        assert (actual === expected) else begin
            count++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    always @(negedge clk_sys) begin
        if (!reset) begin
            check_value("core_reset", 32'(m_hold != 0), 32'(core_reset), model_errors);
            check_value("mapper_sel", m_fld[0], 32'(mapper_sel), model_errors);
            check_value("rumble_en", m_fld[1], 32'(rumble_en), model_errors);
            check_value("sys_type", m_fld[2], 32'(sys_type), model_errors);
            check_value("tint", m_fld[4], 32'(tint), model_errors);
            check_value("sgb_mode", m_fld[5], 32'(sgb_mode), model_errors);
            check_value("sgb_gbc_en", m_fld[6], 32'(sgb_gbc_en), model_errors);
            check_value("rw_en", m_fld[7], 32'(rw_en), model_errors);
            check_value("fast_forward", 32'(m_ff), 32'(fast_forward), model_errors);
            check_value("audio_l", 32'(m_aud_l), 32'(audio_l), model_errors);
            check_value("audio_r", 32'(m_aud_r), 32'(audio_r), model_errors);
            check_value("video_de", 32'(m_de), 32'(video_de), model_errors);
            check_value("video_rgb", 32'(m_rgb), 32'(video_rgb), model_errors);
            check_value("video_vs", 32'(m_vs), 32'(video_vs), model_errors);
            check_value("video_hs", 32'(m_hs), 32'(video_hs), model_errors);
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    // fresh random audio, pixels and data word every cycle
    always @(posedge clk_sys) begin
        audio_l_in <= core_pkg::sample_t'($random(seed));
        audio_r_in <= core_pkg::sample_t'($random(seed));
        lcd_rgb    <= core_pkg::rgb_t'($random(seed));
        rand_word  <= $random(seed);
    end

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_sys);
        bridge_addr    <= addr;
        bridge_wr      <= 1'b1;
        bridge_wr_data <= data;
        @(posedge clk_sys);
        bridge_wr <= 1'b0;
    endtask

    // other key bits stay random, only the fast-forward bit matters
    task automatic hold_key(input logic key, input int cycles);
        repeat (cycles) begin
            @(posedge clk_sys);
            cont1_key <= (rand_word & ~KEY_MASK) | (key ? KEY_MASK : 32'd0);
        end
    endtask

    // call right after the write edge
    task automatic count_hold_cycles(output int n);
        n = 0;
        @(negedge clk_sys);
        while (core_reset && n < TIMEOUT) begin
            n++;
            @(negedge clk_sys);
        end
        if (core_reset) begin
            timeouts++;
            $display("timeout: core_reset never went low after the reset write");
        end
    endtask

    // edges between the one that samples the rise and the output pulse
    task automatic measure_pulse_delay(input logic use_hs, output int n);
        logic pulse;
        @(posedge clk_sys);
        if (use_hs) begin
            lcd_hs <= 1'b1;
        end else begin
            lcd_vs <= 1'b1;
        end
        @(posedge clk_sys);
        @(negedge clk_sys);
        n = 0;
        pulse = use_hs ? video_hs : video_vs;
        while (!pulse && n < TIMEOUT) begin
            @(posedge clk_sys);
            n++;
            @(negedge clk_sys);
            pulse = use_hs ? video_hs : video_vs;
        end
        if (!pulse) begin
            timeouts++;
            $display("timeout: no sync pulse followed the rising lcd sync input");
        end
        @(negedge clk_sys);
        check_value("pulse width", 32'd0, 32'(use_hs ? video_hs : video_vs), directed_errors);
        @(posedge clk_sys);
        lcd_hs <= 1'b0;
        lcd_vs <= 1'b0;
    endtask

    task automatic video_burst(input int cycles);
        repeat (cycles) begin
            @(posedge clk_sys);
            lcd_hblank <= rand_word[0];
            lcd_vblank <= rand_word[1] & rand_word[2];
            lcd_hs     <= (rand_word[5:3] == 3'd0);
            lcd_vs     <= (rand_word[10:6] == 5'd0);
        end
    endtask

    initial begin
        int n;
        repeat (10) @(posedge clk_sys);
        reset <= 1'b0;
        repeat (2) @(posedge clk_sys);

        test_name = "settings";
        for (int round = 0; round < 3; round++) begin
            for (int i = 0; i < 8; i++) begin
                bus_write(field_addr[i], rand_word);
            end
        end
        // near misses must not hit any field
        bus_write(32'h220, rand_word);
        bus_write(32'h054, rand_word);
        bus_write(32'h1200, rand_word);

        test_name = "reset_hold";
        bus_write(core_pkg::ADDR_RESET, rand_word);
        count_hold_cycles(n);
        check_value("hold length", RESET_HOLD, n, directed_errors);
        bus_write(core_pkg::ADDR_RESET, rand_word);
        repeat (8) @(posedge clk_sys);
        bus_write(core_pkg::ADDR_RESET, rand_word);
        count_hold_cycles(n);
        check_value("restarted hold length", RESET_HOLD, n, directed_errors);

        test_name = "ff_tap";
        hold_key(1'b1, 5);
        hold_key(1'b0, 6);
        @(negedge clk_sys);
        check_value("latched after tap", 32'd1, 32'(fast_forward), directed_errors);

        test_name = "audio_mute";
        bus_write(core_pkg::ADDR_FF_SND, 32'd0);
        repeat (12) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("muted audio_l", 32'd0, 32'(audio_l), directed_errors);
        bus_write(core_pkg::ADDR_FF_SND, 32'd1);
        repeat (12) @(posedge clk_sys);

        test_name = "ff_second_tap";
        hold_key(1'b1, 5);
        hold_key(1'b0, 10);
        @(negedge clk_sys);
        check_value("cleared by tap", 32'd0, 32'(fast_forward), directed_errors);
        bus_write(core_pkg::ADDR_FF_SND, 32'd0);
        repeat (8) @(posedge clk_sys);

        test_name = "ff_hold";
        hold_key(1'b1, 40);
        @(negedge clk_sys);
        check_value("high while held", 32'd1, 32'(fast_forward), directed_errors);
        hold_key(1'b0, 4);
        @(negedge clk_sys);
        check_value("low after hold", 32'd0, 32'(fast_forward), directed_errors);

        test_name = "ff_loader_busy";
        @(posedge clk_sys);
        loader_busy <= 1'b1;
        hold_key(1'b1, 5);
        hold_key(1'b0, 6);
        @(negedge clk_sys);
        check_value("key ignored", 32'd0, 32'(fast_forward), directed_errors);
        @(posedge clk_sys);
        loader_busy <= 1'b0;

        test_name = "video_random";
        video_burst(300);
        @(posedge clk_sys);
        lcd_hs     <= 1'b0;
        lcd_vs     <= 1'b0;
        lcd_hblank <= 1'b0;
        lcd_vblank <= 1'b0;
        repeat (12) @(posedge clk_sys);

        test_name = "vs_pulse";
        measure_pulse_delay(1'b0, n);
        check_value("vs delay", 32'd0, n, directed_errors);
        repeat (12) @(posedge clk_sys);

        test_name = "hs_pulse";
        measure_pulse_delay(1'b1, n);
        check_value("hs delay", HS_DLY, n, directed_errors);
        repeat (5) @(posedge clk_sys);
        @(negedge clk_sys);

        $display("errors: %0d model mismatches, %0d directed mismatches, %0d timeouts",
                 model_errors, directed_errors, timeouts);
        if (model_errors + directed_errors + timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* flist.f */
core_pkg.sv
core_settings_if.sv
bridge_config_regs.sv
fast_forward_ctrl.sv
video_sync_shaper.sv
core_glue_top.sv
tb_core_glue.sv

/* run.sh */
#!/bin/sh
# compile and run the core glue testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_core_glue -f flist.f
./obj_dir/Vtb_core_glue > sim.log 2>&1
cat sim.log
if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
